/* Bender.yml */
package:
  name: memfifo

sources:
  - design/memfifo_pkg.sv
  - design/mem_cmd_if.sv
  - design/sync_fifo.sv
  - design/word_store.sv
  - design/transfer_ctrl.sv
  - design/memfifo_top.sv
  - target: simulation
    files:
      - tb/memfifo_assert.sv
      - tb/memfifo_tb.sv

/* build.f */
design/memfifo_pkg.sv
design/mem_cmd_if.sv
design/sync_fifo.sv
design/word_store.sv
design/transfer_ctrl.sv
design/memfifo_top.sv
tb/memfifo_assert.sv
tb/memfifo_tb.sv

/* design/mem_cmd_if.sv */
`timescale 1ns/1ps

interface mem_cmd_if
   import memfifo_pkg::*;
();

   // command channel, taken when en and rdy are both high
   mem_addr_t addr;
   mem_cmd_e  cmd;
   logic      en;
   logic      rdy;

   // write data channel, taken with wdf_wren and wdf_rdy
   word_t     wdf_data;
   logic      wdf_wren;
   logic      wdf_rdy;

   // read return, one pulse per read command
   // in command order, READ_LATENCY cycles after acceptance
   word_t     rd_data;
   logic      rd_valid;

   // transfer controller side
   modport ctrl (
      output addr,
      output cmd,
      output en,
      output wdf_data,
      output wdf_wren,
      input  rdy,
      input  wdf_rdy,
      input  rd_valid
   );

   // memory side
   modport mem (
      input  addr,
      input  cmd,
      input  en,
      input  wdf_data,
      input  wdf_wren,
      output rdy,
      output wdf_rdy,
      output rd_data,
      output rd_valid
   );

endinterface

/* design/memfifo_pkg.sv */
package memfifo_pkg;

   // **************************************************
   // sizes
   // **************************************************

   // one data word
   localparam int WORD_WIDTH     = 32;
   // bulk memory
   localparam int MEM_ADDR_WIDTH = 6;
   localparam int MEM_WORDS      = 64;
   // depth of input and output buffer
   localparam int BUF_DEPTH      = 16;

   // **************************************************
   // transfer control
   // **************************************************

   // a write burst ends after this many words
   localparam int MAX_BURST      = 8;
   // fill needed before a mode may start
   localparam int MIN_BURST      = 4;
   // read commands allowed in flight
   localparam int PENDING_LIMIT  = 6;

   // memory timing
   localparam int READ_LATENCY   = 2;
   localparam int REFRESH_PERIOD = 32;
   localparam int REFRESH_CYCLES = 3;

   // buffer thresholds
   localparam int IN_AE_OFFSET   = 4;
   // pending limit plus read latency still fits
   localparam int OUT_AF_OFFSET  = 8;

   typedef logic [WORD_WIDTH-1:0]     word_t;
   typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
   // one bit wider, an empty memory has MEM_WORDS free
   typedef logic [MEM_ADDR_WIDTH:0]   mem_count_t;
   typedef logic [3:0]                burst_cnt_t;
   typedef logic [2:0]                pending_t;

   typedef enum logic {
      CMD_WRITE = 1'b0,
      CMD_READ  = 1'b1
   } mem_cmd_e;

   typedef enum logic [1:0] {
      MODE_IDLE  = 2'd0,
      MODE_WRITE = 2'd1,
      MODE_READ  = 2'd2
   } xfer_mode_e;

endpackage

/* design/memfifo_top.sv */
`timescale 1ns/1ps

module memfifo_top
   import memfifo_pkg::*;
(
   input  logic        uiclk,
   input  logic        reset_buf,
   // write side
   input  logic        wr_en,
   input  word_t       din,
   output logic        full,
   output logic        almost_full,
   output logic        wr_err,
   // read side
   input  logic        rd_en,
   output word_t       dout,
   output logic        empty,
   output logic        almost_empty,
   output logic        rd_err,
   // status
   output mem_count_t  mem_free,
   output logic [1:0]  err_status
);

   // input buffer to controller
   word_t  in_dout;
   logic   in_empty;
   logic   in_almost_empty;
   logic   in_rd_en;

   // output buffer to controller
   logic   out_almost_full;
   logic   out_wr_err;

   mem_cmd_if mem_bus ();

   // input buffer, user almost-full keeps a burst of margin
   sync_fifo #(
      .DEPTH     (BUF_DEPTH),
      .AF_OFFSET (MIN_BURST),
      .AE_OFFSET (IN_AE_OFFSET)
   ) in_fifo (
      .uiclk        (uiclk),
      .reset_buf    (reset_buf),
      .wr_en        (wr_en),
      .din          (din),
      .full         (full),
      .almost_full  (almost_full),
      .wr_err       (wr_err),
      .rd_en        (in_rd_en),
      .dout         (in_dout),
      .empty        (in_empty),
      .almost_empty (in_almost_empty),
      .rd_err       ()
   );

   transfer_ctrl ctrl (
      .uiclk           (uiclk),
      .reset_buf       (reset_buf),
      .in_empty        (in_empty),
      .in_almost_empty (in_almost_empty),
      .in_dout         (in_dout),
      .in_rd_en        (in_rd_en),
      .out_almost_full (out_almost_full),
      .out_wr_err      (out_wr_err),
      .bus             (mem_bus.ctrl),
      .mem_free        (mem_free),
      .err_status      (err_status)
   );

   word_store mem (
      .uiclk     (uiclk),
      .reset_buf (reset_buf),
      .bus       (mem_bus.mem)
   );

   // output buffer, filled straight from the read return
   sync_fifo #(
      .DEPTH     (BUF_DEPTH),
      .AF_OFFSET (OUT_AF_OFFSET),
      .AE_OFFSET (MIN_BURST)
   ) out_fifo (
      .uiclk        (uiclk),
      .reset_buf    (reset_buf),
      .wr_en        (mem_bus.rd_valid),
      .din          (mem_bus.rd_data),
      .full         (),
      .almost_full  (out_almost_full),
      .wr_err       (out_wr_err),
      .rd_en        (rd_en),
      .dout         (dout),
      .empty        (empty),
      .almost_empty (almost_empty),
      .rd_err       (rd_err)
   );

endmodule

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo
   import memfifo_pkg::*;
#(
   parameter int DEPTH     = BUF_DEPTH,
   parameter int AF_OFFSET = OUT_AF_OFFSET,
   parameter int AE_OFFSET = IN_AE_OFFSET
)
(
   input  logic  uiclk,
   input  logic  reset_buf,
   // write side
   input  logic  wr_en,
   input  word_t din,
   output logic  full,
   output logic  almost_full,
   output logic  wr_err,
   // read side
   input  logic  rd_en,
   output word_t dout,
   output logic  empty,
   output logic  almost_empty,
   output logic  rd_err
);

   word_t                       store [DEPTH];
   logic [$clog2(DEPTH)-1:0]    wr_ptr;
   logic [$clog2(DEPTH)-1:0]    rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]  fill;
   logic                        do_wr;
   logic                        do_rd;

   // requests against full or empty are dropped
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // status flags from the fill count
   assign full         = (fill == DEPTH);
   assign empty        = (fill == 0);
   assign almost_full  = (fill >= DEPTH - AF_OFFSET);
   assign almost_empty = (fill <= AE_OFFSET);

   // fall-through, head word always on dout
   assign dout = store[rd_ptr];

   // storage array
   always_ff @(posedge uiclk)
   begin
      if (do_wr)
         store[wr_ptr] <= din;
   end

   // pointers, fill count and error strobes
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         wr_err <= 1'b0;
         rd_err <= 1'b0;
      end
      else
      begin
         // one cycle pulse after a dropped request
         wr_err <= wr_en && full;
         rd_err <= rd_en && empty;
         if (do_wr)
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         // simultaneous push and pop leaves the count
         if (do_wr && !do_rd)
            fill <= fill + 1'b1;
         else if (do_rd && !do_wr)
            fill <= fill - 1'b1;
      end
   end

endmodule

/* design/transfer_ctrl.sv */
`timescale 1ns/1ps

module transfer_ctrl
   import memfifo_pkg::*;
(
   input  logic        uiclk,
   input  logic        reset_buf,
   // input buffer read side
   input  logic        in_empty,
   input  logic        in_almost_empty,
   input  word_t       in_dout,
   output logic        in_rd_en,
   // output buffer write side
   input  logic        out_almost_full,
   input  logic        out_wr_err,
   // bulk memory
   mem_cmd_if.ctrl     bus,
   // status
   output mem_count_t  mem_free,
   output logic [1:0]  err_status
);

   xfer_mode_e  mode;
   burst_cnt_t  wr_cnt;
   burst_cnt_t  rd_cnt;
   mem_addr_t   wr_addr;
   mem_addr_t   rd_addr;
   pending_t    pending;
   logic        ovf_err;
   logic        udf_err;

   logic        mem_empty;
   logic        enough_free;
   logic        enough_stored;
   logic        wr_active;
   logic        rd_active;
   logic        rd_issue;
   logic        wr_start;
   logic        wr_go;
   logic        wr_stop;
   logic        rd_stop;
   logic        rd_go;

   // **************************************************
   // mode arbitration
   // **************************************************

   assign mem_empty     = (mem_free == mem_count_t'(MEM_WORDS));
   assign enough_free   = (mem_free >= mem_count_t'(MIN_BURST));
   assign enough_stored = (mem_free <= mem_count_t'(MEM_WORDS - MIN_BURST));

   // write mode only moves data while input and write channel allow
   assign wr_active = (mode == MODE_WRITE) && bus.wdf_rdy && !in_empty;
   assign rd_active = (mode == MODE_READ);
   assign rd_issue  = rd_active && bus.rdy;

   // pop in the cycle the write command is registered
   assign in_rd_en = bus.rdy && wr_active;

   // normal start needs a filled input buffer and room in memory
   // a short tail may go when the memory is empty, or when
   // the reader is backed up so the memory fills completely
   assign wr_start = (!in_almost_empty && enough_free) || mem_empty ||
                     (out_almost_full && (mem_free != '0));
   assign wr_go    = wr_start && !in_empty && bus.wdf_rdy;

   // free < 2 allows for the command already in progress
   assign wr_stop  = in_empty || !bus.wdf_rdy ||
                     (wr_cnt >= burst_cnt_t'(MAX_BURST - 1)) ||
                     (mem_free < mem_count_t'(2));

   // read mode blockers
   assign rd_stop  = out_almost_full || (pending == pending_t'(PENDING_LIMIT)) ||
                     (rd_cnt >= burst_cnt_t'(MAX_BURST - 1)) || mem_empty;
   // a short tail is read back once the input side runs dry
   assign rd_go    = !rd_stop && (pending == '0) && (enough_stored || in_almost_empty);

   // read wins a tie, the pending wait then lets writes in
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
         mode <= MODE_IDLE;
      else
      begin
         case (mode)
            MODE_IDLE:
               if (rd_go)
                  mode <= MODE_READ;
               else if (wr_go)
                  mode <= MODE_WRITE;
            MODE_WRITE:
               if (wr_stop)
                  mode <= MODE_IDLE;
            // read mode lasts a single cycle
            default:
               mode <= MODE_IDLE;
         endcase
      end
   end

   // **************************************************
   // command generator
   // **************************************************

   // everything holds while the memory is not ready
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
      begin
         bus.en   <= 1'b0;
         wr_addr  <= '0;
         rd_addr  <= '0;
         mem_free <= mem_count_t'(MEM_WORDS);
         wr_cnt   <= '0;
         rd_cnt   <= '0;
      end
      else if (bus.rdy)
      begin
         if (rd_active)
         begin
            bus.en   <= 1'b1;
            rd_addr  <= rd_addr + 1'b1;
            rd_cnt   <= rd_cnt + 1'b1;
            wr_cnt   <= '0;
            mem_free <= mem_free + 1'b1;
         end
         else if (wr_active)
         begin
            bus.en   <= 1'b1;
            wr_addr  <= wr_addr + 1'b1;
            wr_cnt   <= wr_cnt + 1'b1;
            rd_cnt   <= '0;
            mem_free <= mem_free - 1'b1;
         end
         else
         begin
            bus.en <= 1'b0;
            wr_cnt <= '0;
            rd_cnt <= '0;
         end
      end
   end

   // command payload
   always_ff @(posedge uiclk)
   begin
      if (rd_issue)
      begin
         bus.cmd  <= CMD_READ;
         bus.addr <= rd_addr;
      end
      else if (in_rd_en)
      begin
         bus.cmd      <= CMD_WRITE;
         bus.addr     <= wr_addr;
         bus.wdf_data <= in_dout;
      end
   end

   // write strobe stays up until the data is taken
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
         bus.wdf_wren <= 1'b0;
      else if (in_rd_en)
         bus.wdf_wren <= 1'b1;
      else if (bus.wdf_rdy)
         bus.wdf_wren <= 1'b0;
   end

   // **************************************************
   // pending reads and error flags
   // **************************************************

   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
      begin
         pending <= '0;
         udf_err <= 1'b0;
      end
      else if (bus.rd_valid && !rd_issue)
      begin
         if (pending != '0)
            pending <= pending - 1'b1;
         else
            // data with no read outstanding
            udf_err <= 1'b1;
      end
      else if (!bus.rd_valid && rd_issue)
         pending <= pending + 1'b1;
   end

   // output buffer overflow, sticky
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
         ovf_err <= 1'b0;
      else if (out_wr_err)
         ovf_err <= 1'b1;
   end

   // bit 1 overflow, bit 0 underflow
   assign err_status = {ovf_err, udf_err};

endmodule

/* design/word_store.sv */
`timescale 1ns/1ps

module word_store
   import memfifo_pkg::*;
(
   input logic     uiclk,
   input logic     reset_buf,
   mem_cmd_if.mem  bus
);

   word_t                              mem_array [MEM_WORDS];
   logic [$clog2(REFRESH_PERIOD)-1:0]  refresh_cnt;
   logic                               stall;
   logic                               cmd_take;
   logic [READ_LATENCY-1:0]            valid_pipe;
   word_t                              data_pipe [READ_LATENCY];

   // **************************************************
   // refresh stall
   // **************************************************

   // free running period counter
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
         refresh_cnt <= '0;
      else if (refresh_cnt == REFRESH_PERIOD - 1)
         refresh_cnt <= '0;
      else
         refresh_cnt <= refresh_cnt + 1'b1;
   end

   // last REFRESH_CYCLES of every period are blocked
   assign stall = (refresh_cnt >= REFRESH_PERIOD - REFRESH_CYCLES);

   // both channels drop together, like the DRAM controller
   assign bus.rdy     = !stall;
   assign bus.wdf_rdy = !stall;

   // **************************************************
   // command execution
   // **************************************************

   assign cmd_take = bus.en && bus.rdy;

   // write data arrives together with its command
   always_ff @(posedge uiclk)
   begin
      if (cmd_take && (bus.cmd == CMD_WRITE) && bus.wdf_wren && bus.wdf_rdy)
         mem_array[bus.addr] <= bus.wdf_data;
   end

   // read valid pipe
   // several reads may be in flight, order is kept
   always_ff @(posedge uiclk)
   begin
      if (reset_buf)
         valid_pipe <= '0;
      else
      begin
         valid_pipe[0] <= cmd_take && (bus.cmd == CMD_READ);
         for (int i = 1; i < READ_LATENCY; i++)
            valid_pipe[i] <= valid_pipe[i-1];
      end
   end

   // read data pipe, sampled at acceptance
   always_ff @(posedge uiclk)
   begin
      data_pipe[0] <= mem_array[bus.addr];
      for (int i = 1; i < READ_LATENCY; i++)
         data_pipe[i] <= data_pipe[i-1];
   end

   // last stage goes back to the controller side
   assign bus.rd_valid = valid_pipe[READ_LATENCY-1];
   assign bus.rd_data  = data_pipe[READ_LATENCY-1];

endmodule

/* tb/memfifo_assert.sv */
`timescale 1ns/1ps

module memfifo_assert
   import memfifo_pkg::*;
(
   input logic        uiclk,
   input logic        reset_buf,
   input logic        full,
   input logic        empty,
   input mem_count_t  mem_free,
   input logic [1:0]  err_status
);

   // failures seen so far, read by the testbench
   int fail_count = 0;

   // input buffer full while output buffer empty means data is stuck
   full_not_empty: assert property (
      @(posedge uiclk) disable iff (reset_buf) !(full && empty))
      else
      begin
         fail_count++;
         $error("full and empty are high together");
      end

   // free count stays inside the memory size
   free_in_range: assert property (
      @(posedge uiclk) disable iff (reset_buf) mem_free <= mem_count_t'(MEM_WORDS))
      else
      begin
         fail_count++;
         $error("mem_free above memory size");
      end

   // no overflow, no stray read data
   no_error_flags: assert property (
      @(posedge uiclk) disable iff (reset_buf) err_status == 2'b00)
      else
      begin
         fail_count++;
         $error("err_status set");
      end

endmodule

bind memfifo_top memfifo_assert props (
   .uiclk      (uiclk),
   .reset_buf  (reset_buf),
   .full       (full),
   .empty      (empty),
   .mem_free   (mem_free),
   .err_status (err_status)
);

/* tb/memfifo_tb.sv */
`timescale 1ns/1ps

module memfifo_tb
   import memfifo_pkg::*;
();

   localparam int TRACE_MAX = 64;
   localparam int FULL_SETTLE = 40;

   // trace operation codes
   localparam logic [3:0] OP_WRITE      = 4'h1;
   localparam logic [3:0] OP_READ       = 4'h2;
   localparam logic [3:0] OP_IDLE       = 4'h3;
   localparam logic [3:0] OP_FILL       = 4'h4;
   localparam logic [3:0] OP_READ_EMPTY = 4'h5;
   localparam logic [3:0] OP_DRAIN      = 4'h6;

   logic        uiclk;
   logic        reset_buf;
   logic        wr_en;
   word_t       din;
   logic        full;
   logic        almost_full;
   logic        wr_err;
   logic        rd_en;
   word_t       dout;
   logic        empty;
   logic        almost_empty;
   logic        rd_err;
   mem_count_t  mem_free;
   logic [1:0]  err_status;

   logic [35:0] trace_mem [TRACE_MAX];
   word_t       model_q [$];
   int          errors;
   int          checks;
   int          cycles;
   int          cycle_limit;
   int          trace_len;

   memfifo_top dut (
      .uiclk        (uiclk),
      .reset_buf    (reset_buf),
      .wr_en        (wr_en),
      .din          (din),
      .full         (full),
      .almost_full  (almost_full),
      .wr_err       (wr_err),
      .rd_en        (rd_en),
      .dout         (dout),
      .empty        (empty),
      .almost_empty (almost_empty),
      .rd_err       (rd_err),
      .mem_free     (mem_free),
      .err_status   (err_status)
   );

   // **************************************************
   // clock and cycle limit
   // **************************************************

   initial
   begin
      uiclk = 1'b0;
      forever #4 uiclk = ~uiclk;
   end

   always @(posedge uiclk)
   begin
      cycles = cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit)
      begin
         $display("run stopped: the trace did not finish within %0d cycles", cycle_limit);
         $display("Verification failed");
         $finish;
      end
   end

   // **************************************************
   // per cycle driving and checking
   // **************************************************

   // one clock from falling edge to falling edge
   task automatic drive_cycle(input logic w, input word_t d, input logic r);
      logic want_wr_err;
      logic want_rd_err;
      begin
         // flags are stable here and predict the rising edge
         want_wr_err = w && full;
         want_rd_err = r && empty;
         wr_en = w;
         din   = d;
         rd_en = r;
         @(negedge uiclk);
         checks = checks + 1;
         if (wr_err !== want_wr_err)
         begin
            $display("[ERROR] %0t: wr_err is %b, expected %b", $time, wr_err, want_wr_err);
            errors = errors + 1;
         end
         if (rd_err !== want_rd_err)
         begin
            $display("[ERROR] %0t: rd_err is %b, expected %b", $time, rd_err, want_rd_err);
            errors = errors + 1;
         end
         if (err_status !== 2'b00)
         begin
            $display("[ERROR] %0t: err_status is %b, expected 00", $time, err_status);
            errors = errors + 1;
         end
         // a full buffer is also almost full
         if (full === 1'b1 && almost_full !== 1'b1)
         begin
            $display("[ERROR] %0t: almost_full is %b while full", $time, almost_full);
            errors = errors + 1;
         end
         // an empty buffer is also almost empty
         if (empty === 1'b1 && almost_empty !== 1'b1)
         begin
            $display("[ERROR] %0t: almost_empty is %b while empty", $time, almost_empty);
            errors = errors + 1;
         end
      end
   endtask

   task automatic write_word(input word_t w);
      begin
         while (full)
            drive_cycle(1'b0, '0, 1'b0);
         model_q.push_back(w);
         drive_cycle(1'b1, w, 1'b0);
      end
   endtask

   // random reader stall before popping the head word
   task automatic read_expect(input word_t exp);
      int stall;
      begin
         stall = $urandom % 4;
         repeat (stall)
            drive_cycle(1'b0, '0, 1'b0);
         while (empty)
            drive_cycle(1'b0, '0, 1'b0);
         checks = checks + 1;
         if (dout !== exp)
         begin
            $display("[ERROR] %0t: dout is %h, expected %h", $time, dout, exp);
            errors = errors + 1;
         end
         if (model_q.size() > 0)
            void'(model_q.pop_front());
         drive_cycle(1'b0, '0, 1'b1);
      end
   endtask

   // writer keeps pushing with the reader stalled until full has held
   task automatic fill_until_full(input word_t start);
      int accepted;
      int full_run;
      word_t next_word;
      begin
         accepted = 0;
         full_run = 0;
         while (full_run < FULL_SETTLE)
         begin
            next_word = start + word_t'(accepted);
            if (full)
            begin
               // rejected write carries a different word that would show up if stored
               full_run = full_run + 1;
               drive_cycle(1'b1, ~next_word, 1'b0);
            end
            else
            begin
               full_run = 0;
               model_q.push_back(next_word);
               drive_cycle(1'b1, next_word, 1'b0);
               accepted = accepted + 1;
            end
         end
         checks = checks + 1;
         if (accepted <= 2 * BUF_DEPTH || accepted > 2 * BUF_DEPTH + MEM_WORDS)
         begin
            $display("[ERROR] %0t: %0d words taken before full", $time, accepted);
            errors = errors + 1;
         end
         if (mem_free !== '0)
         begin
            $display("[ERROR] %0t: mem_free is %0d at full, expected 0", $time, mem_free);
            errors = errors + 1;
         end
      end
   endtask

   task automatic read_while_empty();
      begin
         if (empty !== 1'b1)
         begin
            $display("[ERROR] %0t: empty is %b before a read of an empty buffer", $time, empty);
            errors = errors + 1;
         end
         drive_cycle(1'b0, '0, 1'b1);
      end
   endtask

   // **************************************************
   // main sequence
   // **************************************************

   initial
   begin
      logic [3:0] op;
      word_t arg;
      void'($urandom(32'h103ed41e));
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      cycle_limit = 0;
      trace_len   = 0;
      reset_buf   = 1'b1;
      wr_en       = 1'b0;
      din         = '0;
      rd_en       = 1'b0;

      for (int i = 0; i < TRACE_MAX; i++)
         trace_mem[i] = '0;
      $readmemh("tb/memfifo_trace.txt", trace_mem);
      // operation code 0 ends the trace
      while (trace_len < TRACE_MAX && trace_mem[trace_len][35:32] != 4'h0)
         trace_len = trace_len + 1;
      if (trace_len == 0)
      begin
         $display("the trace file holds no operations");
         errors = errors + 1;
      end
      cycle_limit = 40 * trace_len + 1000;

      repeat (2) @(posedge uiclk);
      @(negedge uiclk);
      reset_buf = 1'b0;

      // state right after reset
      checks = checks + 1;
      if (empty !== 1'b1 || full !== 1'b0 || mem_free !== mem_count_t'(MEM_WORDS) ||
          err_status !== 2'b00 || almost_full !== 1'b0 || almost_empty !== 1'b1)
      begin
         $display("[ERROR] %0t: after reset empty %b full %b mem_free %0d err_status %b",
                  $time, empty, full, mem_free, err_status);
         $display("[ERROR] %0t: after reset almost_full %b almost_empty %b",
                  $time, almost_full, almost_empty);
         errors = errors + 1;
      end

      for (int i = 0; i < trace_len; i++)
      begin
         op  = trace_mem[i][35:32];
         arg = trace_mem[i][31:0];
         case (op)
            OP_WRITE:      write_word(arg);
            OP_READ:       read_expect(arg);
            OP_IDLE:       repeat (arg) drive_cycle(1'b0, '0, 1'b0);
            OP_FILL:       fill_until_full(arg);
            OP_READ_EMPTY: read_while_empty();
            OP_DRAIN:
               while (model_q.size() > 0)
                  read_expect(model_q[0]);
            default:
            begin
               $display("unknown operation %h on trace line %0d", op, i);
               errors = errors + 1;
            end
         endcase
      end

      // everything drained and idle
      checks = checks + 1;
      if (mem_free !== mem_count_t'(MEM_WORDS) || empty !== 1'b1 || model_q.size() != 0)
      begin
         $display("[ERROR] %0t: at end mem_free %0d empty %b, %0d words never read",
                  $time, mem_free, empty, model_q.size());
         errors = errors + 1;
      end
      if (almost_full !== 1'b0 || almost_empty !== 1'b1)
      begin
         $display("[ERROR] %0t: at end almost_full %b almost_empty %b, expected 0 and 1",
                  $time, almost_full, almost_empty);
         errors = errors + 1;
      end

      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, dut.props.fail_count);
      if (errors == 0 && dut.props.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* tb/memfifo_trace.txt */
// columns: op code (1 hex digit) then word (8 hex digits)
// op 1 write, 2 read expect, 3 idle n, 4 fill from word, 5 read empty, 6 drain
500000000
1cafe0001
1cafe0002
1cafe0003
300000020
2cafe0001
2cafe0002
2cafe0003
10000a001
10000a002
10000a003
10000a004
10000a005
10000a006
20000a001
20000a002
20000a003
20000a004
20000a005
20000a006
300000028
400010000
200010000
200010001
200010002
200010003
600000000
300000040
500000000
